/* common/cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// datapath and register file
`define DBITS 32
`define REGNOBITS 6
`define IMMBITS 14

// first instruction after reset
`define STARTPC 32'h100

// byte address bits of the instruction and data memories
`define IMEMADDRBITS 16
`define DMEMADDRBITS 16

// memory-mapped output registers
`define ADDRHEX 32'hFFFFF000
`define ADDRLEDR 32'hFFFFF020
`define HEXRESET 24'h123456

`endif

/* common/cpuPkg.sv */
`include "cpu_settings.svh"

package cpuPkg;

  // basic field widths
  typedef logic [`DBITS-1:0] wordT;
  typedef logic [`REGNOBITS-1:0] regNoT;
  typedef logic [`IMMBITS-1:0] immT;

  // primary opcode in bits 31:26
  typedef enum logic [5:0] {
    OP1_ALUR = 6'h00,
    OP1_BEQ  = 6'h08,
    OP1_BLT  = 6'h09,
    OP1_BLE  = 6'h0A,
    OP1_BNE  = 6'h0B,
    OP1_JAL  = 6'h0C,
    OP1_LW   = 6'h12,
    OP1_SW   = 6'h1A,
    OP1_ADDI = 6'h20,
    OP1_ANDI = 6'h24,
    OP1_ORI  = 6'h25,
    OP1_XORI = 6'h26
  } op1T;

  // compares and basic ops reuse the op1 codes
  // bit 3 turns add/and/or/xor into sub/nand/nor/nxor
  typedef enum logic [5:0] {
    ALU_NOP  = 6'h00,
    ALU_EQ   = 6'h08,
    ALU_LT   = 6'h09,
    ALU_LE   = 6'h0A,
    ALU_NE   = 6'h0B,
    ALU_ADD  = 6'h20,
    ALU_AND  = 6'h24,
    ALU_OR   = 6'h25,
    ALU_XOR  = 6'h26,
    ALU_SUB  = 6'h28,
    ALU_NAND = 6'h2C,
    ALU_NOR  = 6'h2D,
    ALU_NXOR = 6'h2E
  } aluFuncT;

  // which value goes back to the register file
  typedef enum logic [1:0] {
    RES_ALU,
    RES_MEM,
    RES_PC
  } resSelT;

  typedef struct packed {
    logic write;
    regNoT regNo;
  } regDestT;

  // fetch to decode
  typedef struct packed {
    wordT inst;
    wordT pcPlus;
  } fetchOutT;

  // decode to execute
  typedef struct packed {
    wordT opA;
    wordT opB;
    wordT offset;
    wordT pcPlus;
    aluFuncT aluFunc;
    logic aluImm;
    logic isBranch;
    logic isJump;
    logic memWrite;
    resSelT resultSel;
    regDestT dest;
  } decodeOutT;

  // execute to memory
  typedef struct packed {
    wordT aluResult;
    wordT storeValue;
    wordT pcPlus;
    logic memWrite;
    resSelT resultSel;
    regDestT dest;
  } execOutT;

endpackage

/* common/stageIf.sv */
`timescale 1ns/10ps

interface stageIf #(
  parameter type payloadT = cpuPkg::wordT
);
  import cpuPkg::*;

  // transfer on a clock edge with both high
  logic valid;
  logic ready;
  // pc plus 4 of the instruction crossing this boundary
  wordT pcPlus;
  // stage specific bundle
  payloadT payload;

  // upstream side
  modport src (
    output valid,
    output pcPlus,
    output payload,
    input ready
  );

  // downstream side
  modport dst (
    input valid,
    input pcPlus,
    input payload,
    output ready
  );

endinterface

/* core/fetchStage.sv */
`timescale 1ns/10ps
`include "cpu_settings.svh"

module fetchStage (
  input logic clk,
  input logic reset,
  input logic progWe,
  input logic [`IMEMADDRBITS-3:0] progAddr,
  input cpuPkg::wordT progData,
  input logic redirectValid,
  input cpuPkg::wordT redirectPc,
  stageIf.src toDecode
);
  import cpuPkg::*;

  localparam int IMEMWORDS = 1 << (`IMEMADDRBITS - 2);

  wordT imem [IMEMWORDS];
  wordT pc;
  wordT pcPlus;
  logic outValid;
  fetchOutT outReg;
  logic advance;

  // program loader, also active while the core sits in reset
  always_ff @(posedge clk) begin
    if (progWe) begin
      imem[progAddr] <= progData;
    end
  end

  assign pcPlus = pc + 32'd4;
  // output slot is empty or decode takes it
  assign advance = !outValid || toDecode.ready;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc <= `STARTPC;
      outValid <= 1'b0;
    end else if (redirectValid) begin
      // restart at the target, held instruction is dropped
      pc <= redirectPc;
      outValid <= 1'b0;
    end else if (advance) begin
      pc <= pcPlus;
      outValid <= 1'b1;
    end
  end

  // word index of the byte pc
  always_ff @(posedge clk) begin
    if (advance) begin
      outReg.inst <= imem[pc[`IMEMADDRBITS-1:2]];
      outReg.pcPlus <= pcPlus;
    end
  end

  // a redirect also kills what decode sees this cycle
  assign toDecode.valid = outValid && !redirectValid;
  assign toDecode.payload = outReg;
  assign toDecode.pcPlus = outReg.pcPlus;

endmodule

/* core/decodeStage.sv */
`timescale 1ns/10ps
`include "cpu_settings.svh"

module decodeStage (
  input logic clk,
  input logic reset,
  stageIf.dst fromFetch,
  stageIf.src toExec,
  input cpuPkg::regDestT exDest,
  input cpuPkg::regDestT memDest,
  input cpuPkg::regDestT wbDest,
  input cpuPkg::wordT wbValue
);
  import cpuPkg::*;

  wordT regs [2**`REGNOBITS];
  wordT inst;
  op1T op1;
  aluFuncT op2;
  regNoT rs;
  regNoT rt;
  regNoT rd;
  immT imm;
  decodeOutT dec;
  logic isBubble;
  logic usesRt;
  regDestT ownDest;
  logic rsBusy;
  logic rtBusy;
  logic hazard;
  logic advance;
  logic outValid;
  decodeOutT outReg;

  function automatic logic writesReg(regDestT d, regNoT r);
    return d.write && (d.regNo == r);
  endfunction

  // fixed field positions
  assign inst = fromFetch.payload.inst;
  assign op1 = op1T'(inst[31:26]);
  assign rs = inst[25:20];
  assign rt = inst[19:14];
  assign rd = inst[13:8];
  assign op2 = aluFuncT'(inst[5:0]);
  assign imm = inst[`IMMBITS-1:0];

  // written at the end of writeback, no bypass to the reads
  always_ff @(posedge clk) begin
    if (wbDest.write) begin
      regs[wbDest.regNo] <= wbValue;
    end
  end

  always_comb begin
    dec.opA = regs[rs];
    dec.opB = regs[rt];
    dec.offset = {{(`DBITS-`IMMBITS){imm[`IMMBITS-1]}}, imm};
    dec.pcPlus = fromFetch.pcPlus;
    dec.aluFunc = ALU_ADD;
    dec.aluImm = 1'b0;
    dec.isBranch = 1'b0;
    dec.isJump = 1'b0;
    dec.memWrite = 1'b0;
    dec.resultSel = RES_ALU;
    dec.dest = '{write: 1'b0, regNo: rt};
    isBubble = 1'b0;
    usesRt = 1'b0;
    case (op1)
      OP1_ALUR: begin
        dec.aluFunc = op2;
        dec.dest = '{write: 1'b1, regNo: rd};
        usesRt = 1'b1;
        case (op2)
          ALU_EQ, ALU_LT, ALU_LE, ALU_NE, ALU_ADD, ALU_AND, ALU_OR, ALU_XOR,
          ALU_SUB, ALU_NAND, ALU_NOR, ALU_NXOR: ;
          // nop and unknown functions
          default: isBubble = 1'b1;
        endcase
      end
      OP1_ADDI, OP1_ANDI, OP1_ORI, OP1_XORI: begin
        dec.aluFunc = aluFuncT'(op1);
        dec.aluImm = 1'b1;
        dec.dest.write = 1'b1;
      end
      OP1_BEQ, OP1_BLT, OP1_BLE, OP1_BNE: begin
        // compare result decides the branch in execute
        dec.aluFunc = aluFuncT'(op1);
        dec.isBranch = 1'b1;
        usesRt = 1'b1;
      end
      OP1_JAL: begin
        // link value is pc plus 4
        dec.isJump = 1'b1;
        dec.resultSel = RES_PC;
        dec.dest.write = 1'b1;
      end
      OP1_LW: begin
        dec.aluImm = 1'b1;
        dec.resultSel = RES_MEM;
        dec.dest.write = 1'b1;
      end
      OP1_SW: begin
        dec.aluImm = 1'b1;
        dec.memWrite = 1'b1;
        usesRt = 1'b1;
      end
      default: isBubble = 1'b1;
    endcase
  end

  // instruction now in execute
  assign ownDest = '{write: outValid && outReg.dest.write, regNo: outReg.dest.regNo};

  // any older write still in flight
  assign rsBusy = writesReg(ownDest, rs) || writesReg(exDest, rs) ||
                  writesReg(memDest, rs) || writesReg(wbDest, rs);
  assign rtBusy = writesReg(ownDest, rt) || writesReg(exDest, rt) ||
                  writesReg(memDest, rt) || writesReg(wbDest, rt);
  assign hazard = fromFetch.valid && !isBubble && (rsBusy || (usesRt && rtBusy));

  assign advance = !outValid || toExec.ready;
  assign fromFetch.ready = advance && !hazard;

  // squashed input arrives with valid low and leaves a bubble
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      outValid <= 1'b0;
    end else if (advance) begin
      outValid <= fromFetch.valid && !hazard && !isBubble;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      outReg <= dec;
    end
  end

  assign toExec.valid = outValid;
  assign toExec.payload = outReg;
  assign toExec.pcPlus = outReg.pcPlus;

  // producers drain within the pipeline depth
  stallBounded: assert property (@(posedge clk) disable iff (reset)
    $fell(fromFetch.ready) |-> ##[1:4] fromFetch.ready);

endmodule

/* core/executeStage.sv */
`timescale 1ns/10ps
`include "cpu_settings.svh"

module executeStage (
  input logic clk,
  input logic reset,
  stageIf.dst fromDecode,
  stageIf.src toMem,
  output cpuPkg::regDestT exDest,
  output logic redirectValid,
  output cpuPkg::wordT redirectPc
);
  import cpuPkg::*;

  decodeOutT d;
  logic signed [`DBITS-1:0] aluA;
  logic signed [`DBITS-1:0] aluB;
  wordT aluOut;
  wordT branchTarget;
  wordT jumpTarget;
  logic takeIn;
  logic taken;
  logic advance;
  logic outValid;
  execOutT outReg;

  assign d = fromDecode.payload;
  assign aluA = d.opA;
  // offset for immediates and address calc
  assign aluB = d.aluImm ? d.offset : d.opB;

  // signed ops, compares give 0 or 1
  always_comb begin
    case (d.aluFunc)
      ALU_EQ:   aluOut = wordT'(aluA == aluB);
      ALU_LT:   aluOut = wordT'(aluA < aluB);
      ALU_LE:   aluOut = wordT'(aluA <= aluB);
      ALU_NE:   aluOut = wordT'(aluA != aluB);
      ALU_ADD:  aluOut = aluA + aluB;
      ALU_AND:  aluOut = aluA & aluB;
      ALU_OR:   aluOut = aluA | aluB;
      ALU_XOR:  aluOut = aluA ^ aluB;
      ALU_SUB:  aluOut = aluA - aluB;
      ALU_NAND: aluOut = ~(aluA & aluB);
      ALU_NOR:  aluOut = ~(aluA | aluB);
      ALU_NXOR: aluOut = ~(aluA ^ aluB);
      default:  aluOut = '0;
    endcase
  end

  // word offsets
  assign branchTarget = fromDecode.pcPlus + (d.offset << 2);
  assign jumpTarget = d.opA + (d.offset << 2);

  assign advance = !outValid || toMem.ready;
  assign fromDecode.ready = advance;
  // instruction right behind a redirect is on the wrong path
  assign takeIn = fromDecode.valid && !redirectValid;
  assign taken = d.isJump || (d.isBranch && aluOut[0]);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      outValid <= 1'b0;
      redirectValid <= 1'b0;
    end else begin
      redirectValid <= advance && takeIn && taken;
      if (advance) begin
        outValid <= takeIn;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      outReg.aluResult <= aluOut;
      outReg.storeValue <= d.opB;
      outReg.pcPlus <= fromDecode.pcPlus;
      outReg.memWrite <= d.memWrite;
      outReg.resultSel <= d.resultSel;
      outReg.dest <= d.dest;
    end
    redirectPc <= d.isJump ? jumpTarget : branchTarget;
  end

  // bubbles never look like pending writes
  assign exDest = '{write: outValid && outReg.dest.write, regNo: outReg.dest.regNo};

  assign toMem.valid = outValid;
  assign toMem.payload = outReg;
  assign toMem.pcPlus = outReg.pcPlus;

  // a redirect from either squashed slot behind it means a squash was missed
  redirectSingle: assert property (@(posedge clk) disable iff (reset)
    redirectValid |=> !redirectValid ##1 !redirectValid);

endmodule

/* core/memoryStage.sv */
`timescale 1ns/10ps
`include "cpu_settings.svh"

module memoryStage (
  input logic clk,
  input logic reset,
  stageIf.dst fromExec,
  output cpuPkg::regDestT memDest,
  output cpuPkg::regDestT wbDest,
  output cpuPkg::wordT wbValue,
  output logic [23:0] hex,
  output logic [9:0] ledr
);
  import cpuPkg::*;

  localparam int DMEMWORDS = 1 << (`DMEMADDRBITS - 2);

  wordT dmem [DMEMWORDS];
  execOutT e;
  wordT addr;
  logic selDmem;
  logic selHex;
  logic selLedr;
  logic store;
  wordT loadValue;
  wordT result;
  logic wbWrite;
  regNoT wbRegNo;

  assign e = fromExec.payload;
  assign addr = e.aluResult;
  // low 64k is data memory, two fixed output registers above
  assign selDmem = (addr[`DBITS-1:`DMEMADDRBITS] == '0);
  assign selHex = (addr == `ADDRHEX);
  assign selLedr = (addr == `ADDRLEDR);
  assign store = fromExec.valid && e.memWrite;
  assign fromExec.ready = 1'b1;

  always_ff @(posedge clk) begin
    if (store && selDmem) begin
      dmem[addr[`DMEMADDRBITS-1:2]] <= e.storeValue;
    end
  end

  // stores land at the end of the memory cycle
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hex <= `HEXRESET;
      ledr <= '0;
    end else begin
      if (store && selHex) begin
        hex <= e.storeValue[23:0];
      end
      if (store && selLedr) begin
        ledr <= e.storeValue[9:0];
      end
    end
  end

  // output registers read back zero extended
  always_comb begin
    if (selDmem) begin
      loadValue = dmem[addr[`DMEMADDRBITS-1:2]];
    end else if (selHex) begin
      loadValue = wordT'(hex);
    end else if (selLedr) begin
      loadValue = wordT'(ledr);
    end else begin
      loadValue = '0;
    end
  end

  always_comb begin
    case (e.resultSel)
      RES_MEM: result = loadValue;
      RES_PC:  result = fromExec.pcPlus;
      default: result = e.aluResult;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wbWrite <= 1'b0;
    end else begin
      wbWrite <= fromExec.valid && e.dest.write;
    end
  end

  always_ff @(posedge clk) begin
    wbRegNo <= e.dest.regNo;
    wbValue <= result;
  end

  // same instruction as the write port, seen as a hazard source
  assign memDest = '{write: wbWrite, regNo: wbRegNo};
  assign wbDest = '{write: wbWrite, regNo: wbRegNo};

endmodule

/* hdl/cpuTop.sv */
`timescale 1ns/10ps
`include "cpu_settings.svh"

module cpuTop (
  input logic clk,
  input logic reset,
  input logic progWe,
  input logic [`IMEMADDRBITS-3:0] progAddr,
  input cpuPkg::wordT progData,
  output logic [23:0] hex,
  output logic [9:0] ledr
);
  import cpuPkg::*;

  // hazard and writeback feedback into decode
  regDestT exDest;
  regDestT memDest;
  regDestT wbDest;
  wordT wbValue;
  // taken branch or jump back to fetch
  logic redirectValid;
  wordT redirectPc;

  // one boundary per pipeline register
  stageIf #(.payloadT(fetchOutT)) fetchToDecode ();
  stageIf #(.payloadT(decodeOutT)) decodeToExec ();
  stageIf #(.payloadT(execOutT)) execToMem ();

  fetchStage fetch (
    .clk(clk),
    .reset(reset),
    .progWe(progWe),
    .progAddr(progAddr),
    .progData(progData),
    .redirectValid(redirectValid),
    .redirectPc(redirectPc),
    .toDecode(fetchToDecode)
  );

  decodeStage decode (
    .clk(clk),
    .reset(reset),
    .fromFetch(fetchToDecode),
    .toExec(decodeToExec),
    .exDest(exDest),
    .memDest(memDest),
    .wbDest(wbDest),
    .wbValue(wbValue)
  );

  executeStage execute (
    .clk(clk),
    .reset(reset),
    .fromDecode(decodeToExec),
    .toMem(execToMem),
    .exDest(exDest),
    .redirectValid(redirectValid),
    .redirectPc(redirectPc)
  );

  memoryStage memory (
    .clk(clk),
    .reset(reset),
    .fromExec(execToMem),
    .memDest(memDest),
    .wbDest(wbDest),
    .wbValue(wbValue),
    .hex(hex),
    .ledr(ledr)
  );

endmodule

/* verification/cpuChecker.sv */
`timescale 1ns/10ps

module cpuChecker (
  input logic clk,
  input logic reset,
  input logic [23:0] hex,
  input logic [9:0] ledr,
  input int testNo,
  input logic [23:0] expHex,
  input logic [9:0] expLedr,
  output int errorCount,
  output int doneCount
);

  // output register values while the core is in reset
  localparam logic [23:0] hexAtReset = 24'h123456;
  localparam logic [9:0] ledrAtReset = 10'h000;

  logic [23:0] lastHex;
  logic [9:0] lastLedr;

  initial begin
    errorCount = 0;
    doneCount = 0;
  end

  // outputs change on the rising edge, so sample on the falling one
  always @(negedge clk) begin
    if (reset) begin
      if (hex !== hexAtReset || ledr !== ledrAtReset) begin
        $display("MISMATCH at %0t ns: test %0d reset state hex=%h ledr=%h, expected %h %h",
                 $time, testNo, hex, ledr, hexAtReset, ledrAtReset);
        errorCount++;
      end
    end else begin
      // one HEX store per program, so any other value is a wrong-path store
      if (hex !== lastHex && hex !== expHex) begin
        $display("MISMATCH at %0t ns: test %0d HEX written with %h, expected %h",
                 $time, testNo, hex, expHex);
        errorCount++;
      end
      // done mark just arrived, each row ends with its expected LEDR value
      if (ledr !== lastLedr && ledr === expLedr) begin
        if (hex !== expHex) begin
          $display("MISMATCH at %0t ns: test %0d final HEX %h, expected %h",
                   $time, testNo, hex, expHex);
          errorCount++;
        end
        doneCount++;
      end
    end
    lastHex = hex;
    lastLedr = ledr;
  end

endmodule

/* verification/cpuTb.sv */
`timescale 1ns/10ps

module cpuTb;
  import cpuPkg::*;

  localparam int numTests = 6;
  localparam int rowWords = 16;
  // word index of byte address 0x100
  localparam logic [13:0] startWord = 14'h40;
  localparam int cyclesPerTest = 300;
  localparam int cycleLimit = cyclesPerTest * numTests;
  // HEX and LEDR reached from r1 = 0 with a negative offset
  localparam int hexOffset = -4096;
  localparam int ledrOffset = -4064;

  logic clk;
  logic reset;
  logic progWe;
  logic [13:0] progAddr;
  wordT progData;
  logic [23:0] hex;
  logic [9:0] ledr;

  // stimulus and expected results, one row per test
  wordT programRom [numTests][rowWords];
  logic [23:0] expHexTable [numTests];
  logic [9:0] expLedrTable [numTests];
  int rowNo;
  int wordNo;

  int testNo;
  logic [23:0] expHex;
  logic [9:0] expLedr;
  int errorCount;
  int doneCount;
  int testsRun;
  int cycleCount = 0;

  cpuTop DUT (
    .clk(clk),
    .reset(reset),
    .progWe(progWe),
    .progAddr(progAddr),
    .progData(progData),
    .hex(hex),
    .ledr(ledr)
  );

  cpuChecker outputCheck (
    .clk(clk),
    .reset(reset),
    .hex(hex),
    .ledr(ledr),
    .testNo(testNo),
    .expHex(expHex),
    .expLedr(expLedr),
    .errorCount(errorCount),
    .doneCount(doneCount)
  );

  always #20 clk = ~clk;

  // register op, rd = rs func rt
  function automatic wordT aluOp(aluFuncT func, regNoT rd, regNoT rs, regNoT rt);
    return {OP1_ALUR, rs, rt, rd, 2'b00, func};
  endfunction

  // immediate, load, store and jal format
  function automatic wordT immOp(op1T op, regNoT rt, regNoT rs, int imm);
    logic [31:0] immBits;
    immBits = imm;
    return {op, rs, rt, immBits[13:0]};
  endfunction

  // compares rs against rt, offset in words from pc plus 4
  function automatic wordT branchOp(op1T op, regNoT rs, regNoT rt, int offset);
    return immOp(op, rt, rs, offset);
  endfunction

  task automatic emit(input wordT inst);
    programRom[rowNo][wordNo] = inst;
    wordNo++;
  endtask

  // result to HEX, mark to LEDR, then spin on a jump to itself
  task automatic finishRow(input regNoT resultReg, input int markValue,
                           input logic [23:0] hexValue);
    logic [31:0] markBits;
    markBits = markValue;
    emit(immOp(OP1_SW, resultReg, 1, hexOffset));
    emit(immOp(OP1_ADDI, 62, 1, markValue));
    emit(immOp(OP1_SW, 62, 1, ledrOffset));
    // target is 0 plus 4 times the jump's own word index
    emit(immOp(OP1_JAL, 63, 1, startWord + wordNo));
    // zero word is an ALUR nop, a bubble
    while (wordNo < rowWords) begin
      emit(32'h0);
    end
    expHexTable[rowNo] = hexValue;
    // LEDR keeps the low 10 bits
    expLedrTable[rowNo] = markBits[9:0];
    rowNo++;
    wordNo = 0;
  endtask

  task automatic buildTable();
    // dependent chain, every op waits on the one before
    emit(immOp(OP1_ANDI, 1, 1, 0));
    emit(immOp(OP1_ADDI, 2, 1, 300));
    emit(immOp(OP1_ADDI, 3, 1, -7));
    emit(aluOp(ALU_ADD, 4, 2, 3));
    emit(aluOp(ALU_SUB, 4, 3, 4));
    emit(aluOp(ALU_NAND, 5, 4, 2));
    emit(aluOp(ALU_NOR, 5, 5, 3));
    emit(aluOp(ALU_XOR, 5, 5, 2));
    emit(aluOp(ALU_NXOR, 6, 5, 4));
    emit(aluOp(ALU_AND, 6, 6, 3));
    emit(aluOp(ALU_OR, 6, 6, 4));
    finishRow(6, 'h2A5, 24'hFFFED5);

    // immediates are sign extended from 14 bits
    emit(immOp(OP1_ANDI, 1, 1, 0));
    emit(immOp(OP1_ADDI, 2, 1, -1000));
    emit(immOp(OP1_ANDI, 3, 2, -16));
    emit(immOp(OP1_ORI, 4, 3, 7));
    emit(immOp(OP1_XORI, 5, 4, -1));
    emit(immOp(OP1_ADDI, 6, 5, -2000));
    emit(immOp(OP1_XORI, 6, 6, 'hA5A));
    finishRow(6, 'h2A5, 24'hFFF642);

    // taken branches, each skips a HEX store of 0xBAD
    emit(immOp(OP1_ANDI, 1, 1, 0));
    emit(immOp(OP1_ADDI, 2, 1, -5));
    emit(immOp(OP1_ADDI, 3, 1, 3));
    emit(immOp(OP1_ADDI, 7, 1, 'hBAD));
    emit(branchOp(OP1_BLT, 2, 3, 1));
    emit(immOp(OP1_SW, 7, 1, hexOffset));
    emit(branchOp(OP1_BLE, 3, 3, 1));
    emit(immOp(OP1_SW, 7, 1, hexOffset));
    emit(branchOp(OP1_BNE, 2, 3, 1));
    emit(immOp(OP1_SW, 7, 1, hexOffset));
    emit(branchOp(OP1_BEQ, 3, 3, 1));
    emit(immOp(OP1_SW, 7, 1, hexOffset));
    finishRow(2, 'h2A5, 24'hFFFFFB);

    // not taken, each fall-through adds its own bits
    emit(immOp(OP1_ANDI, 1, 1, 0));
    emit(immOp(OP1_ADDI, 2, 1, -5));
    emit(immOp(OP1_ADDI, 3, 1, 3));
    emit(branchOp(OP1_BEQ, 2, 3, 1));
    emit(immOp(OP1_ADDI, 4, 1, 'h11));
    // signed compare, 3 is not below -5
    emit(branchOp(OP1_BLT, 3, 2, 1));
    emit(immOp(OP1_ADDI, 4, 4, 'h220));
    emit(branchOp(OP1_BLE, 3, 2, 1));
    emit(immOp(OP1_ADDI, 4, 4, 'h400));
    emit(branchOp(OP1_BNE, 3, 3, 1));
    emit(immOp(OP1_ADDI, 4, 4, 'h1800));
    finishRow(4, 'h2A5, 24'h001E31);

    // two jumps, HEX gets the sum of both links
    emit(immOp(OP1_ANDI, 1, 1, 0));
    emit(immOp(OP1_ADDI, 7, 1, 'hBAD));
    emit(immOp(OP1_ADDI, 2, 1, 'h40));
    // at 0x10C, to 0x40 + 4 * 0x37 = 0x11C, link 0x110
    emit(immOp(OP1_JAL, 3, 2, 'h37));
    emit(immOp(OP1_SW, 7, 1, hexOffset));
    emit(immOp(OP1_SW, 7, 1, hexOffset));
    emit(immOp(OP1_SW, 7, 1, hexOffset));
    // at 0x11C, to 0x124, link 0x120
    emit(immOp(OP1_JAL, 4, 1, 'h49));
    emit(immOp(OP1_SW, 7, 1, hexOffset));
    emit(aluOp(ALU_ADD, 5, 3, 4));
    finishRow(5, 'h2A5, 24'h000230);

    // data memory round trip and LEDR readback
    emit(immOp(OP1_ANDI, 1, 1, 0));
    emit(immOp(OP1_ADDI, 2, 1, -1234));
    emit(immOp(OP1_ADDI, 3, 1, 'h200));
    emit(immOp(OP1_SW, 2, 3, 8));
    // 0xFFFFFD55 leaves 0x155 in LEDR
    emit(immOp(OP1_ADDI, 4, 1, -683));
    emit(immOp(OP1_SW, 4, 1, ledrOffset));
    emit(immOp(OP1_LW, 5, 3, 8));
    emit(immOp(OP1_LW, 6, 1, ledrOffset));
    emit(aluOp(ALU_ADD, 7, 5, 6));
    // wide mark, only 0x2A5 lands in LEDR
    finishRow(7, 'h12A5, 24'hFFFC83);
  endtask

  // reset, load while held, release, wait for the done mark
  task automatic runTest(input int t);
    int startDone;
    @(posedge clk);
    reset <= 1'b1;
    testNo <= t;
    expHex <= expHexTable[t];
    expLedr <= expLedrTable[t];
    repeat (4) @(posedge clk);
    for (int i = 0; i < rowWords; i++) begin
      progWe <= 1'b1;
      progAddr <= startWord + i;
      progData <= programRom[t][i];
      @(posedge clk);
    end
    progWe <= 1'b0;
    reset <= 1'b0;
    startDone = doneCount;
    while (doneCount == startDone) begin
      @(posedge clk);
    end
    testsRun++;
  endtask

  // run limit from the table length
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("timeout: test %0d never wrote the done mark to LEDR within %0d cycles",
               testNo, cycleLimit);
      $display("errors: %0d, tests completed: %0d of %0d", errorCount, testsRun, numTests);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    progWe = 1'b0;
    progAddr = '0;
    progData = '0;
    testNo = 0;
    expHex = '0;
    expLedr = '0;
    testsRun = 0;
    rowNo = 0;
    wordNo = 0;
    buildTable();
    for (int t = 0; t < numTests; t++) begin
      runTest(t);
    end
    // let the checker see the last falling edge
    @(posedge clk);
    $display("errors: %0d, tests completed: %0d of %0d", errorCount, testsRun, numTests);
    if (errorCount == 0 && testsRun == numTests) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+common
common/cpuPkg.sv
common/stageIf.sv
core/fetchStage.sv
core/decodeStage.sv
core/executeStage.sv
core/memoryStage.sv
hdl/cpuTop.sv
verification/cpuChecker.sv
verification/cpuTb.sv
